//--- Makefile
# Verilator flow for the execution stage
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f vlog.f --top-module tb_exu

sim:
	verilator --binary --timing --assert -f vlog.f --top-module tb_exu -o Vtb_exu
	./obj_dir/Vtb_exu > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "RESULT: PASS" $(LOG); then echo "Simulation ended without a result"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf obj_dir $(LOG)

//--- exu_alu.sv
/*
  Single-cycle integer ALU.
  Loads come in decoded as ADD with the immediate, so the result is the address.
*/
`timescale 1ns/100ps

module exu_alu (
  input  exu_pkg::dec_t              i_dec,
  input  logic [exu_pkg::XLEN-1:0]   i_rs1,
  input  logic [exu_pkg::XLEN-1:0]   i_rs2,
  output logic [exu_pkg::XLEN-1:0]   o_result
);

  logic [exu_pkg::XLEN-1:0] op2;

  assign op2 = i_dec.use_imm ? i_dec.imm : i_rs2;

  always_comb begin
    case (i_dec.op)
      exu_pkg::ALU_SUB: o_result = i_rs1 - op2;
      exu_pkg::ALU_AND: o_result = i_rs1 & op2;
      exu_pkg::ALU_OR:  o_result = i_rs1 | op2;
      exu_pkg::ALU_XOR: o_result = i_rs1 ^ op2;
      default:          o_result = i_rs1 + op2;  // ADD, ADDI, LW address
    endcase
  end

endmodule

//--- exu_commit.sv
/*
  WFI control: drain outstanding loads, halt dispatch, wake on i_irq.
  i_irq is a level and is sampled only in CMT_HALT.
*/
`timescale 1ns/100ps

module exu_commit (
  input  logic clk,
  input  logic i_arst_n,
  input  logic i_wfi_ena,
  input  logic i_oitf_empty,
  input  logic i_irq,
  output logic o_busy,
  output logic o_core_wfi
);

  exu_pkg::cmt_state_e state_q, state_d;

  ///////////////////////////////
  // Next state
  ///////////////////////////////
  always_comb begin
    state_d = state_q;
    case (state_q)
      exu_pkg::CMT_IDLE: begin
        if (i_wfi_ena) state_d = exu_pkg::CMT_DRAIN;
      end
      exu_pkg::CMT_DRAIN: begin
        if (i_oitf_empty) state_d = exu_pkg::CMT_HALT;  // Last load back
      end
      exu_pkg::CMT_HALT: begin
        if (i_irq) state_d = exu_pkg::CMT_IDLE;
      end
      default: state_d = exu_pkg::CMT_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_q <= exu_pkg::CMT_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign o_busy     = (state_q != exu_pkg::CMT_IDLE);
  assign o_core_wfi = (state_q == exu_pkg::CMT_HALT);

  // Dispatch holds ready low outside idle
  a_wfi_in_idle: assert property (@(posedge clk) disable iff (!i_arst_n)
    i_wfi_ena |-> (state_q == exu_pkg::CMT_IDLE))
    else $error("WFI accepted while commit busy");

endmodule

//--- exu_decode.sv
/*
  Combinational decode of one instruction word.
  Anything outside the subset decodes to a no-op with no reads or writes.
*/
`timescale 1ns/100ps

module exu_decode (
  input  logic [exu_pkg::INSTR_W-1:0] i_ir,
  output exu_pkg::dec_t               o_dec
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       rd_wr;   // Legal op that writes rd

  assign opcode = i_ir[6:0];
  assign funct3 = i_ir[14:12];
  assign funct7 = i_ir[31:25];

  always_comb begin
    o_dec        = '0;
    o_dec.op     = exu_pkg::ALU_ADD;
    o_dec.rs1idx = i_ir[19:15];
    o_dec.rs2idx = i_ir[24:20];
    o_dec.rdidx  = i_ir[11:7];
    o_dec.imm    = {{20{i_ir[31]}}, i_ir[31:20]};
    rd_wr        = 1'b0;
    case (opcode)
      exu_pkg::OPC_OP: begin
        o_dec.rs1en = 1'b1;
        o_dec.rs2en = 1'b1;
        rd_wr       = 1'b1;
        case ({funct7, funct3})
          {7'h00, 3'b000}: o_dec.op = exu_pkg::ALU_ADD;
          {7'h20, 3'b000}: o_dec.op = exu_pkg::ALU_SUB;
          {7'h00, 3'b111}: o_dec.op = exu_pkg::ALU_AND;
          {7'h00, 3'b110}: o_dec.op = exu_pkg::ALU_OR;
          {7'h00, 3'b100}: o_dec.op = exu_pkg::ALU_XOR;
          default: begin
            o_dec.rs1en = 1'b0;
            o_dec.rs2en = 1'b0;
            rd_wr       = 1'b0;
          end
        endcase
      end
      exu_pkg::OPC_OPIMM: begin
        if (funct3 == 3'b000) begin  // ADDI
          o_dec.rs1en   = 1'b1;
          o_dec.use_imm = 1'b1;
          rd_wr         = 1'b1;
        end
      end
      exu_pkg::OPC_LOAD: begin
        if (funct3 == 3'b010) begin  // LW, address via ADD
          o_dec.rs1en    = 1'b1;
          o_dec.use_imm  = 1'b1;
          o_dec.longpipe = 1'b1;
          rd_wr          = 1'b1;
        end
      end
      exu_pkg::OPC_SYSTEM: o_dec.wfi = (i_ir == exu_pkg::WFI_INSTR);
      default: ;
    endcase
    o_dec.rdwen = rd_wr & (i_ir[11:7] != '0);
  end

endmodule

//--- exu_disp.sv
/*
  Dispatch: ready generation and steering of the accepted instruction.
  Purely combinational; a load is issued on its acceptance cycle.
*/
`timescale 1ns/100ps

module exu_disp (
  input  logic                         i_valid,
  output logic                         o_ready,
  input  exu_pkg::dec_t                i_dec,
  input  logic [exu_pkg::XLEN-1:0]     i_alu_result,
  input  logic                         i_match_rs1,
  input  logic                         i_match_rs2,
  input  logic                         i_match_rd,
  input  logic                         i_oitf_full,
  input  logic                         i_oitf_empty,
  input  logic                         i_alu_ready,
  input  logic                         i_busy,
  output exu_pkg::wbck_t               o_alu_wbck,
  output logic                         o_oitf_ena,
  output exu_pkg::lsu_cmd_t            o_lsu_cmd,
  input  logic [exu_pkg::ITAG_W-1:0]   i_dis_ptr,
  output logic                         o_wfi_ena,
  output logic                         o_exu_active
);

  logic raw_waw;    // Hazard against a pending load
  logic full_stall;
  logic wb_stall;   // Load return owns the write port
  logic accept;

  assign raw_waw    = i_match_rs1 | i_match_rs2 | i_match_rd;
  assign full_stall = i_dec.longpipe & i_oitf_full;
  assign wb_stall   = i_dec.rdwen & ~i_dec.longpipe & ~i_alu_ready;
  assign o_ready    = ~(raw_waw | full_stall | wb_stall | i_busy);
  assign accept     = i_valid & o_ready;

  assign o_alu_wbck.ena   = accept & i_dec.rdwen & ~i_dec.longpipe;
  assign o_alu_wbck.rdidx = i_dec.rdidx;
  assign o_alu_wbck.wdat  = i_alu_result;

  assign o_oitf_ena      = accept & i_dec.longpipe;
  assign o_lsu_cmd.valid = o_oitf_ena;
  assign o_lsu_cmd.itag  = i_dis_ptr;
  assign o_lsu_cmd.addr  = i_alu_result;  // rs1 + imm

  assign o_wfi_ena    = accept & i_dec.wfi;
  assign o_exu_active = ~i_oitf_empty | i_valid | i_busy;

endmodule

//--- exu_oitf.sv
/*
  Outstanding-instruction FIFO for loads.
  Returns must come back in order; the itag is the entry index.
  OITF_DEPTH must be a power of two.
*/
`timescale 1ns/100ps

module exu_oitf (
  input  logic                          clk,
  input  logic                          i_arst_n,
  input  logic                          i_dis_ena,
  input  logic [exu_pkg::RFIDX_W-1:0]   i_dis_rdidx,
  output logic [exu_pkg::ITAG_W-1:0]    o_dis_ptr,
  output logic                          o_full,
  output logic                          o_empty,
  input  exu_pkg::lsu_wbck_t            i_lsu_wbck,
  output logic [exu_pkg::RFIDX_W-1:0]   o_ret_rdidx,
  input  exu_pkg::dec_t                 i_dec,
  output logic                          o_match_rs1,
  output logic                          o_match_rs2,
  output logic                          o_match_rd
);

  logic [exu_pkg::ITAG_W-1:0]     wptr_q, rptr_q;
  logic                           wflag_q, rflag_q;  // Wrap flags
  logic [exu_pkg::ITAG_W:0]       cnt_q;
  logic [exu_pkg::RFIDX_W-1:0]    rd_q [exu_pkg::OITF_DEPTH];
  logic [exu_pkg::ITAG_W-1:0]     ofs [exu_pkg::OITF_DEPTH];
  logic [exu_pkg::OITF_DEPTH-1:0] vld, hit_rs1, hit_rs2, hit_rd;
  logic                           ret_ena;

  assign ret_ena     = i_lsu_wbck.valid;
  assign o_empty     = (wptr_q == rptr_q) & (wflag_q == rflag_q);
  assign o_full      = (wptr_q == rptr_q) & (wflag_q != rflag_q);
  assign o_dis_ptr   = wptr_q;
  assign o_ret_rdidx = rd_q[rptr_q];

  ///////////////////////////////
  // Pointers and occupancy
  ///////////////////////////////
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      wflag_q <= 1'b0;
      rflag_q <= 1'b0;
      cnt_q   <= '0;
    end else begin
      if (i_dis_ena) begin
        wptr_q <= wptr_q + 1'b1;
        if (wptr_q == exu_pkg::ITAG_W'(exu_pkg::OITF_DEPTH - 1)) wflag_q <= ~wflag_q;
      end
      if (ret_ena) begin
        rptr_q <= rptr_q + 1'b1;
        if (rptr_q == exu_pkg::ITAG_W'(exu_pkg::OITF_DEPTH - 1)) rflag_q <= ~rflag_q;
      end
      case ({i_dis_ena, ret_ena})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: ;  // Both or neither, no change
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (i_dis_ena) rd_q[wptr_q] <= i_dis_rdidx;
  end

  ///////////////////////////////
  // Destination match
  ///////////////////////////////
  always_comb begin
    for (int i = 0; i < exu_pkg::OITF_DEPTH; i++) begin
      ofs[i]     = exu_pkg::ITAG_W'(i) - rptr_q;  // Distance from head
      vld[i]     = ({1'b0, ofs[i]} < cnt_q);
      hit_rs1[i] = vld[i] & (rd_q[i] == i_dec.rs1idx);
      hit_rs2[i] = vld[i] & (rd_q[i] == i_dec.rs2idx);
      hit_rd[i]  = vld[i] & (rd_q[i] == i_dec.rdidx);
    end
  end

  // x0 sources never wait
  assign o_match_rs1 = (|hit_rs1) & i_dec.rs1en & (i_dec.rs1idx != '0);
  assign o_match_rs2 = (|hit_rs2) & i_dec.rs2en & (i_dec.rs2idx != '0);
  assign o_match_rd  = (|hit_rd) & i_dec.rdwen;

  a_ret_in_order: assert property (@(posedge clk) disable iff (!i_arst_n)
    ret_ena |-> (!o_empty && (i_lsu_wbck.itag == rptr_q)))
    else $error("load return with empty FIFO or wrong itag");

  a_no_alloc_full: assert property (@(posedge clk) disable iff (!i_arst_n)
    i_dis_ena |-> !o_full)
    else $error("FIFO allocation while full");

endmodule

//--- exu_pkg.sv
/*
  Shared widths, encodings and bundles of the execution stage.
  OITF_DEPTH must be a power of two and match ITAG_W.
  Only the RV32I subset ADD/SUB/AND/OR/XOR/ADDI/LW/WFI is decoded.
*/
package exu_pkg;

  localparam int XLEN       = 32;
  localparam int RFIDX_W    = 5;
  localparam int INSTR_W    = 32;
  localparam int OITF_DEPTH = 2;
  localparam int ITAG_W     = 1;

  localparam logic [INSTR_W-1:0] WFI_INSTR = 32'h1050_0073;

  // Major opcodes of the supported subset
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'b0000011,
    OPC_OPIMM  = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR} alu_op_e;

  typedef enum logic [1:0] {CMT_IDLE, CMT_DRAIN, CMT_HALT} cmt_state_e;

  typedef struct packed {
    alu_op_e            op;
    logic [RFIDX_W-1:0] rs1idx;
    logic [RFIDX_W-1:0] rs2idx;
    logic [RFIDX_W-1:0] rdidx;
    logic               rs1en;
    logic               rs2en;
    logic               rdwen;     // Never set for x0
    logic               use_imm;
    logic [XLEN-1:0]    imm;       // Sign extended I-type
    logic               longpipe;  // Loads
    logic               wfi;
  } dec_t;

  typedef struct packed {
    logic               ena;
    logic [RFIDX_W-1:0] rdidx;
    logic [XLEN-1:0]    wdat;
  } wbck_t;

  typedef struct packed {
    logic              valid;
    logic [ITAG_W-1:0] itag;
    logic [XLEN-1:0]   addr;
  } lsu_cmd_t;

  typedef struct packed {
    logic              valid;
    logic [ITAG_W-1:0] itag;
    logic [XLEN-1:0]   wdat;
  } lsu_wbck_t;

endpackage

//--- exu_regfile.sv
/*
  32x32 integer register file with one write port.
  A load return always takes the port; the ALU must wait on o_alu_ready.
*/
`timescale 1ns/100ps

module exu_regfile (
  input  logic                           clk,
  input  logic                           i_arst_n,
  input  logic [exu_pkg::RFIDX_W-1:0]    i_rs1idx,
  input  logic [exu_pkg::RFIDX_W-1:0]    i_rs2idx,
  output logic [exu_pkg::XLEN-1:0]       o_rs1,
  output logic [exu_pkg::XLEN-1:0]       o_rs2,
  input  exu_pkg::wbck_t                 i_alu_wbck,
  input  exu_pkg::lsu_wbck_t             i_lsu_wbck,
  input  logic [exu_pkg::RFIDX_W-1:0]    i_ret_rdidx,
  output logic                           o_alu_ready,
  output exu_pkg::wbck_t                 o_wbck
);

  logic [exu_pkg::XLEN-1:0] rf_q [1:2**exu_pkg::RFIDX_W-1];  // x0 not stored

  assign o_alu_ready = ~i_lsu_wbck.valid;

  // Write port arbitration, load return first
  always_comb begin
    if (i_lsu_wbck.valid) begin
      o_wbck.ena   = (i_ret_rdidx != '0);  // Load to x0 is dropped
      o_wbck.rdidx = i_ret_rdidx;
      o_wbck.wdat  = i_lsu_wbck.wdat;
    end else begin
      o_wbck = i_alu_wbck;
    end
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int i = 1; i < 2**exu_pkg::RFIDX_W; i++) begin
        rf_q[i] <= '0;
      end
    end else if (o_wbck.ena) begin
      rf_q[o_wbck.rdidx] <= o_wbck.wdat;
    end
  end

  assign o_rs1 = (i_rs1idx == '0) ? '0 : rf_q[i_rs1idx];
  assign o_rs2 = (i_rs2idx == '0) ? '0 : rf_q[i_rs2idx];

  // Decode and FIFO keep x0 off the write port
  a_no_x0_write: assert property (@(posedge clk) disable iff (!i_arst_n)
    o_wbck.ena |-> (o_wbck.rdidx != '0))
    else $error("regfile write to x0");

endmodule

//--- exu_top.sv
/*
  Execution stage top: decode, regfile, ALU, load FIFO, dispatch, WFI control.
  i_ir must stay stable while i_valid is high and o_ready is low.
  i_lsu_wbck returns in order and never in the cycle of issue.
*/
`timescale 1ns/100ps

module exu_top (
  input  logic                          clk,
  input  logic                          i_arst_n,
  input  logic                          i_valid,
  output logic                          o_ready,
  input  logic [exu_pkg::INSTR_W-1:0]   i_ir,
  output exu_pkg::lsu_cmd_t             o_lsu_cmd,
  input  exu_pkg::lsu_wbck_t            i_lsu_wbck,
  output exu_pkg::wbck_t                o_wbck,
  input  logic                          i_irq,
  output logic                          o_core_wfi,
  output logic                          o_oitf_empty,
  output logic                          o_exu_active
);

  exu_pkg::dec_t                 dec;
  exu_pkg::wbck_t                alu_wbck;
  logic [exu_pkg::XLEN-1:0]      rf_rs1, rf_rs2, alu_result;
  logic [exu_pkg::RFIDX_W-1:0]   ret_rdidx;
  logic [exu_pkg::ITAG_W-1:0]    dis_ptr;
  logic                          alu_ready, oitf_full, oitf_ena;
  logic                          match_rs1, match_rs2, match_rd;
  logic                          wfi_ena, cmt_busy;

  exu_decode u_exu_decode (
    .i_ir  (i_ir),
    .o_dec (dec)
  );

  exu_regfile u_exu_regfile (
    .clk         (clk),
    .i_arst_n    (i_arst_n),
    .i_rs1idx    (dec.rs1idx),
    .i_rs2idx    (dec.rs2idx),
    .o_rs1       (rf_rs1),
    .o_rs2       (rf_rs2),
    .i_alu_wbck  (alu_wbck),
    .i_lsu_wbck  (i_lsu_wbck),
    .i_ret_rdidx (ret_rdidx),
    .o_alu_ready (alu_ready),
    .o_wbck      (o_wbck)
  );

  exu_alu u_exu_alu (
    .i_dec    (dec),
    .i_rs1    (rf_rs1),
    .i_rs2    (rf_rs2),
    .o_result (alu_result)
  );

  exu_oitf u_exu_oitf (
    .clk         (clk),
    .i_arst_n    (i_arst_n),
    .i_dis_ena   (oitf_ena),
    .i_dis_rdidx (dec.rdidx),
    .o_dis_ptr   (dis_ptr),
    .o_full      (oitf_full),
    .o_empty     (o_oitf_empty),
    .i_lsu_wbck  (i_lsu_wbck),
    .o_ret_rdidx (ret_rdidx),
    .i_dec       (dec),
    .o_match_rs1 (match_rs1),
    .o_match_rs2 (match_rs2),
    .o_match_rd  (match_rd)
  );

  exu_disp u_exu_disp (
    .i_valid      (i_valid),
    .o_ready      (o_ready),
    .i_dec        (dec),
    .i_alu_result (alu_result),
    .i_match_rs1  (match_rs1),
    .i_match_rs2  (match_rs2),
    .i_match_rd   (match_rd),
    .i_oitf_full  (oitf_full),
    .i_oitf_empty (o_oitf_empty),
    .i_alu_ready  (alu_ready),
    .i_busy       (cmt_busy),
    .o_alu_wbck   (alu_wbck),
    .o_oitf_ena   (oitf_ena),
    .o_lsu_cmd    (o_lsu_cmd),
    .i_dis_ptr    (dis_ptr),
    .o_wfi_ena    (wfi_ena),
    .o_exu_active (o_exu_active)
  );

  exu_commit u_exu_commit (
    .clk          (clk),
    .i_arst_n     (i_arst_n),
    .i_wfi_ena    (wfi_ena),
    .i_oitf_empty (o_oitf_empty),
    .i_irq        (i_irq),
    .o_busy       (cmt_busy),
    .o_core_wfi   (o_core_wfi)
  );

endmodule

//--- tb_exu.sv
/*
  Self-checking testbench for exu_top with a shadow register model.
  Register indices are drawn from x0..x7 so load hazards come up often.
  The load unit answers in order, 0 to MAX_DLY cycles after the issue edge.
  Stimulus comes from a fixed-seed LFSR, so every run is the same.
*/
`timescale 1ns/100ps

module tb_exu;

  localparam int CLK_NS      = 4;
  localparam int N_INSTR     = 400;
  localparam int MAX_DLY     = 7;
  localparam int MAX_WAIT    = 4 * MAX_DLY + 16;
  localparam int WATCHDOG_NS = N_INSTR * (2 * MAX_WAIT + 8) * CLK_NS + 1000;
  localparam logic [31:0] SEED = 32'h5bc53f35;

  typedef enum logic [3:0] {
    K_ADD, K_SUB, K_AND, K_OR, K_XOR, K_ADDI, K_LW, K_WFI, K_ILL
  } kind_e;

  typedef struct packed {
    kind_e                       kind;
    logic [exu_pkg::RFIDX_W-1:0] rd;
    logic [exu_pkg::RFIDX_W-1:0] rs1;
    logic [exu_pkg::RFIDX_W-1:0] rs2;
    logic [exu_pkg::XLEN-1:0]    imm;
    logic [2:0]                  dly;   // Load return delay
    logic [exu_pkg::XLEN-1:0]    data;  // Load return data
  } instr_t;

  typedef struct packed {
    int                          due;   // Earliest cycle of return
    logic [exu_pkg::RFIDX_W-1:0] rd;
    logic [exu_pkg::ITAG_W-1:0]  itag;
    logic [exu_pkg::XLEN-1:0]    data;
  } pend_t;

  logic                        clk;
  logic                        i_arst_n;
  logic                        i_valid;
  logic                        o_ready;
  logic [exu_pkg::INSTR_W-1:0] i_ir;
  exu_pkg::lsu_cmd_t           o_lsu_cmd;
  exu_pkg::lsu_wbck_t          i_lsu_wbck;
  exu_pkg::wbck_t              o_wbck;
  logic                        i_irq;
  logic                        o_core_wfi;
  logic                        o_oitf_empty;
  logic                        o_exu_active;

  // Model state
  logic [exu_pkg::XLEN-1:0]   shadow [32] = '{default: '0};
  pend_t                      pend_q [$];
  instr_t                     cur;
  logic [31:0]                lfsr_q = SEED;
  logic [exu_pkg::ITAG_W-1:0] exp_tag = '0;
  logic                       wfi_blk = 1'b0;   // WFI accepted, no interrupt yet
  int                         cycle = 0;
  int                         n_acc = 0;
  int                         n_seen = 0;

  exu_top u_exu_top (
    .clk          (clk),
    .i_arst_n     (i_arst_n),
    .i_valid      (i_valid),
    .o_ready      (o_ready),
    .i_ir         (i_ir),
    .o_lsu_cmd    (o_lsu_cmd),
    .i_lsu_wbck   (i_lsu_wbck),
    .o_wbck       (o_wbck),
    .i_irq        (i_irq),
    .o_core_wfi   (o_core_wfi),
    .o_oitf_empty (o_oitf_empty),
    .o_exu_active (o_exu_active)
  );

  initial begin : clock_gen
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  //////////////////////////////
  // Reporting
  //////////////////////////////
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_mismatch(input string sig, input logic [31:0] exp,
                                 input logic [31:0] act);
    abort_run($sformatf("CHECK FAILED at %0d ns: %s expected 0x%08h actual 0x%08h",
                        $time, sig, exp, act));
  endtask

  //////////////////////////////
  // Stimulus helpers
  //////////////////////////////
  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      r      = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic instr_t pick_instr();
    instr_t     in;
    logic [3:0] sel;
    logic [11:0] i12;
    sel     = 4'(rand_bits(4));
    in.rd   = 5'(rand_bits(3));
    in.rs1  = 5'(rand_bits(3));
    in.rs2  = 5'(rand_bits(3));
    i12     = 12'(rand_bits(12));
    in.imm  = {{20{i12[11]}}, i12};
    in.dly  = 3'(rand_bits(3));
    in.data = rand_bits(32);
    case (sel)
      4'd0, 4'd1:             in.kind = K_ADD;
      4'd2, 4'd14:            in.kind = K_SUB;
      4'd3:                   in.kind = K_AND;
      4'd4:                   in.kind = K_OR;
      4'd5, 4'd15:            in.kind = K_XOR;
      4'd6, 4'd7:             in.kind = K_ADDI;
      4'd8, 4'd9, 4'd10, 4'd11: in.kind = K_LW;
      4'd12: begin
        in.kind = K_ILL;
        in.imm  = rand_bits(25);  // Random upper bits of the word
      end
      default:                in.kind = K_WFI;
    endcase
    return in;
  endfunction

  function automatic logic [31:0] encode(input instr_t in);
    case (in.kind)
      K_ADD:   return {7'h00, in.rs2, in.rs1, 3'b000, in.rd, 7'b0110011};
      K_SUB:   return {7'h20, in.rs2, in.rs1, 3'b000, in.rd, 7'b0110011};
      K_AND:   return {7'h00, in.rs2, in.rs1, 3'b111, in.rd, 7'b0110011};
      K_OR:    return {7'h00, in.rs2, in.rs1, 3'b110, in.rd, 7'b0110011};
      K_XOR:   return {7'h00, in.rs2, in.rs1, 3'b100, in.rd, 7'b0110011};
      K_ADDI:  return {in.imm[11:0], in.rs1, 3'b000, in.rd, 7'b0010011};
      K_LW:    return {in.imm[11:0], in.rs1, 3'b010, in.rd, 7'b0000011};
      K_WFI:   return 32'h1050_0073;
      default: return {in.imm[24:0], 7'b0001011};  // custom-0, not decoded
    endcase
  endfunction

  //////////////////////////////
  // Reference rules
  //////////////////////////////
  function automatic logic [31:0] alu_ref(input instr_t in, input logic [31:0] a,
                                          input logic [31:0] b);
    case (in.kind)
      K_ADD:        return a + b;
      K_SUB:        return a - b;
      K_AND:        return a & b;
      K_OR:         return a | b;
      K_XOR:        return a ^ b;
      K_ADDI, K_LW: return a + in.imm;  // LW gives the address
      default:      return '0;
    endcase
  endfunction

  function automatic logic is_alu_write(input instr_t in);
    return (in.kind <= K_ADDI) && (in.rd != '0);
  endfunction

  // Source or destination hits the rd of a pending load
  function automatic logic uses_pending(input instr_t in);
    logic hit;
    hit = 1'b0;
    foreach (pend_q[i]) begin
      if (pend_q[i].rd != '0) begin
        if ((in.kind <= K_LW) && (in.rs1 == pend_q[i].rd)) hit = 1'b1;
        if ((in.kind <= K_XOR) && (in.rs2 == pend_q[i].rd)) hit = 1'b1;
        if ((in.kind <= K_LW) && (in.rd == pend_q[i].rd)) hit = 1'b1;
      end
    end
    return hit;
  endfunction

  //////////////////////////////
  // Edge checker and model
  //////////////////////////////
  always @(posedge clk) begin : check_edge
    logic                        acc;
    logic                        exp_act;
    logic                        exp_ena;
    logic [exu_pkg::RFIDX_W-1:0] exp_rd;
    logic [exu_pkg::XLEN-1:0]    exp_dat;
    logic [exu_pkg::XLEN-1:0]    res;
    pend_t                       p;
    cycle = cycle + 1;
    if (i_arst_n) begin
      acc = i_valid && o_ready;
      res = alu_ref(cur, shadow[cur.rs1], shadow[cur.rs2]);
      assert (o_oitf_empty == (pend_q.size() == 0))
        else report_mismatch("o_oitf_empty", 32'(pend_q.size() == 0), 32'(o_oitf_empty));
      // Busy while loads are out, an instruction is offered or a WFI is open
      exp_act = (pend_q.size() != 0) || i_valid || wfi_blk;
      assert (o_exu_active == exp_act)
        else report_mismatch("o_exu_active", 32'(exp_act), 32'(o_exu_active));
      if (o_core_wfi) begin
        assert (wfi_blk) else abort_run("o_core_wfi high with no WFI accepted");
      end
      if (acc) begin
        assert (!wfi_blk) else abort_run("instruction accepted after WFI before the interrupt");
        assert (!uses_pending(cur)) else abort_run("instruction accepted on a pending load rd");
        if (cur.kind == K_LW) begin
          assert (pend_q.size() < 2) else abort_run("load accepted with two loads pending");
        end
        if (is_alu_write(cur)) begin
          assert (!i_lsu_wbck.valid) else abort_run("ALU write accepted during a load return");
        end
        n_acc = n_acc + 1;
      end
      // Load return owns the write port
      exp_ena = 1'b0;
      exp_rd  = '0;
      exp_dat = '0;
      if (i_lsu_wbck.valid) begin
        exp_ena = (pend_q[0].rd != '0);
        exp_rd  = pend_q[0].rd;
        exp_dat = pend_q[0].data;
      end else if (acc && is_alu_write(cur)) begin
        exp_ena = 1'b1;
        exp_rd  = cur.rd;
        exp_dat = res;
      end
      assert (o_wbck.ena == exp_ena)
        else report_mismatch("o_wbck.ena", 32'(exp_ena), 32'(o_wbck.ena));
      if (exp_ena) begin
        assert (o_wbck.rdidx == exp_rd)
          else report_mismatch("o_wbck.rdidx", 32'(exp_rd), 32'(o_wbck.rdidx));
        assert (o_wbck.wdat == exp_dat) else report_mismatch("o_wbck.wdat", exp_dat, o_wbck.wdat);
      end
      assert (o_lsu_cmd.valid == (acc && (cur.kind == K_LW)))
        else report_mismatch("o_lsu_cmd.valid", 32'(acc && (cur.kind == K_LW)),
                             32'(o_lsu_cmd.valid));
      if (o_lsu_cmd.valid) begin
        assert (o_lsu_cmd.addr == res) else report_mismatch("o_lsu_cmd.addr", res, o_lsu_cmd.addr);
        assert (o_lsu_cmd.itag == exp_tag)
          else report_mismatch("o_lsu_cmd.itag", 32'(exp_tag), 32'(o_lsu_cmd.itag));
      end
      // Advance the model past this edge
      if (exp_ena) shadow[exp_rd] = exp_dat;
      if (i_lsu_wbck.valid) p = pend_q.pop_front();
      if (acc && (cur.kind == K_LW)) begin
        p.due  = cycle + int'(cur.dly);
        p.rd   = cur.rd;
        p.itag = exp_tag;
        p.data = cur.data;
        pend_q.push_back(p);
        exp_tag = exp_tag + 1'b1;
      end
      if (acc && (cur.kind == K_WFI)) wfi_blk = 1'b1;
      if (o_core_wfi && i_irq) wfi_blk = 1'b0;
    end
  end

  no_x0_write: assert property (@(posedge clk) disable iff (!i_arst_n)
    o_wbck.ena |-> (o_wbck.rdidx != '0))
    else abort_run("write-back enabled for register x0");

  wfi_after_drain: assert property (@(posedge clk) disable iff (!i_arst_n)
    o_core_wfi |-> o_oitf_empty)
    else abort_run("o_core_wfi high with loads still pending");

  wfi_ends_on_irq: assert property (@(posedge clk) disable iff (!i_arst_n)
    $fell(o_core_wfi) |-> $past(i_irq))
    else abort_run("o_core_wfi fell without an interrupt");

  // In-order load unit
  initial begin : load_unit
    i_lsu_wbck = '0;
    forever begin
      @(negedge clk);
      if ((pend_q.size() != 0) && (pend_q[0].due <= cycle)) begin
        i_lsu_wbck.valid = 1'b1;
        i_lsu_wbck.itag  = pend_q[0].itag;
        i_lsu_wbck.wdat  = pend_q[0].data;
      end else begin
        i_lsu_wbck = '0;
      end
    end
  end

  //////////////////////////////
  // Driver
  //////////////////////////////
  task automatic offer(input instr_t in);
    cur     = in;
    i_ir    = encode(in);
    i_valid = 1'b1;
  endtask

  task automatic wait_accept();
    int t;
    t = 0;
    while (n_acc == n_seen) begin
      @(negedge clk);
      t++;
      if (t > MAX_WAIT) abort_run("instruction not accepted within the wait limit");
    end
    n_seen = n_acc;
  endtask

  task automatic wake_from_wfi();
    int t;
    t = 0;
    while (!o_core_wfi) begin
      @(negedge clk);
      t++;
      if (t > MAX_WAIT) abort_run("o_core_wfi did not rise after WFI");
    end
    repeat (rand_bits(2)) @(negedge clk);
    i_irq = 1'b1;
    t = 0;
    while (o_core_wfi) begin
      @(negedge clk);
      t++;
      if (t > MAX_WAIT) abort_run("o_core_wfi did not fall after the interrupt");
    end
    i_irq = 1'b0;
  endtask

  initial begin : drive_stim
    int   k;
    int   t;
    logic was_wfi;
    i_arst_n = 1'b0;
    i_valid  = 1'b0;
    i_ir     = '0;
    i_irq    = 1'b0;
    cur      = '0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    assert (!o_lsu_cmd.valid && !o_wbck.ena && !o_core_wfi && o_oitf_empty)
      else abort_run("outputs not at their reset values");
    i_arst_n = 1'b1;
    k = 0;
    offer(pick_instr());
    while (k < N_INSTR) begin
      wait_accept();
      k++;
      was_wfi = (cur.kind == K_WFI);
      if (rand_bits(2) == 0) begin  // Idle bubble
        i_valid = 1'b0;
        @(negedge clk);
      end
      if (k < N_INSTR) offer(pick_instr());
      else i_valid = 1'b0;
      if (was_wfi) wake_from_wfi();
    end
    t = 0;
    while (pend_q.size() != 0) begin
      @(negedge clk);
      t++;
      if (t > MAX_WAIT) abort_run("loads still pending at end of run");
    end
    repeat (2) @(negedge clk);
    $display("RESULT: PASS");
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    abort_run("watchdog timeout, run did not finish");
  end

endmodule

//--- vlog.f
exu_pkg.sv
exu_decode.sv
exu_regfile.sv
exu_alu.sv
exu_oitf.sv
exu_disp.sv
exu_commit.sv
exu_top.sv
tb_exu.sv
